/* sim.f */
common/am_lock_pkg.sv
common/am_compare_if.sv
am_lock/am_comparator.sv
am_lock/am_period_timer.sv
am_lock/am_lock_fsm.sv
am_lock/bip_calculator.sv
am_lock/bip_error_counter.sv
logic/am_lock_top.sv
verif/am_lock_tb.sv

/* verif/am_lock_tb.sv */
// am lock testbench
`timescale 1ns/10ps

module am_lock_tb;

	localparam int AM_PERIOD   = 64;	// short period for simulation
	localparam int MAX_VALID   = 3;
	localparam int MAX_INVALID = 3;
	localparam int NB_ERR      = 32;
	localparam int N_PERIODS   = 25;	// marker periods in the run plus flush
	localparam int WATCHDOG_NS = N_PERIODS * AM_PERIOD * 4 * 2;
	localparam int GOOD_LANE   = 7;
	localparam int WRONG_LANE  = 3;

	// sync 10, type 1E, eight idle codes
	localparam logic [65:0] IDLE_REF = {2'b10, 8'h1E, 56'h0};

	// lane markers {M0,M1,M2,M4,M5,M6}
	localparam logic [47:0] LANE_AM [20] = '{
		48'hC16821_3E97DE, 48'h9D718E_628E71, 48'h594BE8_A6B417, 48'h4D957B_B26A84,
		48'hF50709_0AF8F6, 48'hDD14C2_22EB3D, 48'h9A4A26_65B5D9, 48'h7B4566_84BA99,
		48'hA02476_5FDB89, 48'h68C9FB_973604, 48'hFD6C99_029366, 48'hB99155_466EAA,
		48'h5CB9B2_A3464D, 48'h1AF8BD_E50742, 48'h83C7CA_7C3835, 48'hC4314C_3BCEB3,
		48'hADD6B7_522948, 48'h5F662A_A099D5, 48'hC0F0E5_3F0F1A, 48'h262C97_D9D368
	};

	logic              i_clock = 1'b0;
	logic              i_reset;
	logic              i_enable;
	logic              i_valid;
	logic              i_block_lock;
	logic [65:0]       i_data;
	logic [2:0]        i_max_valid_am;
	logic [2:0]        i_max_invalid_am;
	logic [65:0]       o_data;
	logic              o_valid;
	logic [4:0]        o_lane_id;
	logic              o_am_lock;
	logic              o_resync;
	logic              o_start_of_lane;
	logic [NB_ERR-1:0] o_error_count;

	integer      seed = 9518;	// payload and gap source
	int          errors;
	int          blocks_checked;
	logic        gaps_on;	// random i_valid holes
	logic [65:0] exp_data_q [$];	// expected output blocks
	logic [7:0]  exp_flag_q [$];	// {lane, lock, start of lane, resync}
	int          exp_err_q [$];
	logic [65:0] e_data;
	logic [7:0]  e_flag;
	int          e_err;

	// marker level reference model
	int          m_state;	// 0 search, 1 count, 2 locked
	int          m_lane;
	int          vcnt;
	int          icnt;
	logic        m_lock;
	logic        m_armed;	// a whole period gathered in lock
	int          m_err;
	int          exp_sol_total;
	int          exp_resync_total;
	int          sol_seen;
	int          resync_seen;
	logic [7:0]  bip_run;	// parity from previous marker on

	am_lock_top
	#(
		.AM_PERIOD        (AM_PERIOD),
		.NB_ERROR_COUNTER (NB_ERR),
		.NB_VAL_AM        (3),
		.NB_INV_AM        (3)
	)
	am_lock_top_i
	(
		.i_clock          (i_clock),
		.i_reset          (i_reset),
		.i_enable         (i_enable),
		.i_valid          (i_valid),
		.i_block_lock     (i_block_lock),
		.i_data           (i_data),
		.i_max_valid_am   (i_max_valid_am),
		.i_max_invalid_am (i_max_invalid_am),
		.o_data           (o_data),
		.o_valid          (o_valid),
		.o_lane_id        (o_lane_id),
		.o_am_lock        (o_am_lock),
		.o_resync         (o_resync),
		.o_start_of_lane  (o_start_of_lane),
		.o_error_count    (o_error_count)
	);

	always #2 i_clock = ~i_clock;	// 4 ns period

	// bit j is the xor of block bits j, j+8, j+16 ...
	function automatic logic [7:0] block_parity(input logic [65:0] blk);
		logic [7:0] p;
		p = 8'h00;
		for (int j = 0; j < 8; j++)
			for (int b = j; b < 66; b += 8)
				p[j] = p[j] ^ blk[b];
		return p;
	endfunction

	function automatic logic [65:0] expected_block(input logic [65:0] blk,
		input logic is_marker, input logic locked);
		if (is_marker && locked)
			return IDLE_REF;	// marker slot swapped while locked
		else
			return blk;
	endfunction

	task automatic report_mismatch(input string what, input logic [65:0] got,
		input logic [65:0] want);
		errors++;
		$display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, want);
	endtask

	// lock and bip rules applied to one marker slot
	task automatic step_lock_model(input int lane, input logic bip_bad,
		output logic sol, output logic rsy);
		logic lock_before;
		lock_before = m_lock;
		sol = 1'b0;
		rsy = 1'b0;
		if (lock_before && m_armed && bip_bad)
			m_err++;
		case (m_state)
			0:
			begin
				m_lane  = lane;	// any lane captures
				vcnt    = 1;
				m_state = 1;
			end
			1:
			begin
				if (lane != m_lane)
					m_state = 0;
				else if (vcnt + 1 >= MAX_VALID)
				begin
					m_state = 2;
					m_lock  = 1'b1;
					sol     = 1'b1;
					icnt    = 0;
				end
				else
					vcnt++;
			end
			default:
			begin
				if (lane == m_lane)
				begin
					icnt = 0;	// one good marker clears
					sol  = 1'b1;
				end
				else if (icnt + 1 >= MAX_INVALID)
				begin
					m_state = 0;
					m_lock  = 1'b0;
					rsy     = 1'b1;
				end
				else
					icnt++;
			end
		endcase
		m_armed = lock_before && m_lock;
		exp_sol_total    += sol;
		exp_resync_total += rsy;
	endtask

	task automatic push_block(input logic [65:0] blk, input logic [65:0] exp_blk,
		input logic [7:0] flags);
		@(negedge i_clock);
		while (gaps_on && (($random(seed) & 3) == 0))
		begin
			i_valid = 1'b0;	// hole in about one of four cycles
			@(negedge i_clock);
		end
		i_valid = 1'b1;
		i_data  = blk;
		exp_data_q.push_back(exp_blk);
		exp_flag_q.push_back(flags);
		exp_err_q.push_back(m_err);
	endtask

	task automatic send_marker(input int lane, input logic bip_bad);
		logic [47:0] am;
		logic [7:0]  bip3;
		logic [65:0] blk;
		logic [65:0] exp_blk;
		logic        sol;
		logic        rsy;
		am      = LANE_AM[lane];
		bip3    = bip_bad ? ~bip_run : bip_run;	// corrupt on request
		blk     = {2'b10, am[47:24], bip3, am[23:0], ~bip3};
		exp_blk = expected_block(blk, 1'b1, m_lock);
		step_lock_model(lane, bip_bad, sol, rsy);
		bip_run = block_parity(blk);	// next period starts with this marker
		push_block(blk, exp_blk, {m_lane[4:0], m_lock, sol, rsy});
	endtask

	task automatic send_period(input int lane, input logic bip_bad);
		logic [65:0] blk;
		send_marker(lane, bip_bad);
		repeat (AM_PERIOD - 1)
		begin
			blk     = {2'b01, $random(seed), $random(seed)};	// sync 01 never matches a marker
			bip_run = bip_run ^ block_parity(blk);
			push_block(blk, expected_block(blk, 1'b0, m_lock), {m_lane[4:0], m_lock, 2'b00});
		end
	endtask

	task automatic apply_reset();
		i_reset = 1'b1;
		i_valid = 1'b0;
		repeat (3) @(negedge i_clock);
		i_reset  = 1'b0;
		m_state  = 0;
		m_lane   = 0;
		vcnt     = 0;
		icnt     = 0;
		m_lock   = 1'b0;
		m_armed  = 1'b0;
		m_err    = 0;
		bip_run  = 8'h00;
		exp_sol_total    = 0;
		exp_resync_total = 0;
		sol_seen         = 0;
		resync_seen      = 0;
	endtask

	task automatic check_reset_outputs();
		if (o_am_lock !== 1'b0)
			report_mismatch("o_am_lock after reset", o_am_lock, 0);
		if (o_resync !== 1'b0)
			report_mismatch("o_resync after reset", o_resync, 0);
		if (o_start_of_lane !== 1'b0)
			report_mismatch("o_start_of_lane after reset", o_start_of_lane, 0);
		if (o_valid !== 1'b0)
			report_mismatch("o_valid after reset", o_valid, 0);
		if (o_error_count !== '0)
			report_mismatch("o_error_count after reset", o_error_count, 0);
	endtask

	// stop the stream and let the pipeline drain
	task automatic flush_and_check();
		@(negedge i_clock);
		i_valid = 1'b0;
		while (exp_data_q.size() != 0)
			@(negedge i_clock);
		@(negedge i_clock);
		if (o_error_count !== m_err)
			report_mismatch("final o_error_count", o_error_count, m_err);
		if (sol_seen != exp_sol_total)
			report_mismatch("o_start_of_lane pulses", sol_seen, exp_sol_total);
		if (resync_seen != exp_resync_total)
			report_mismatch("o_resync pulses", resync_seen, exp_resync_total);
	endtask

	// outputs are stable at the falling edge
	always @(negedge i_clock)
	begin
		if (!i_reset && (o_valid === 1'b1))
		begin
			if (exp_data_q.size() == 0)
			begin
				errors++;
				$display("output block at %0d ns with no block expected", $time);
			end
			else
			begin
				e_data = exp_data_q.pop_front();
				e_flag = exp_flag_q.pop_front();
				e_err  = exp_err_q.pop_front();
				blocks_checked++;
				if (o_data !== e_data)
					report_mismatch("o_data", o_data, e_data);
				if (o_am_lock !== e_flag[2])
					report_mismatch("o_am_lock", o_am_lock, e_flag[2]);
				if (e_flag[2] && (o_lane_id !== e_flag[7:3]))
					report_mismatch("o_lane_id", o_lane_id, e_flag[7:3]);
				if (o_start_of_lane !== e_flag[1])
					report_mismatch("o_start_of_lane", o_start_of_lane, e_flag[1]);
				if (o_resync !== e_flag[0])
					report_mismatch("o_resync", o_resync, e_flag[0]);
				if (o_error_count !== e_err)
					report_mismatch("o_error_count", o_error_count, e_err);
			end
		end
		if (o_resync === 1'b1)
			resync_seen++;
		if (o_start_of_lane === 1'b1)
			sol_seen++;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: run still busy after %0d ns", WATCHDOG_NS);
		$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		errors           = 0;
		blocks_checked   = 0;
		gaps_on          = 1'b0;
		i_reset          = 1'b1;
		i_enable         = 1'b1;
		i_valid          = 1'b0;
		i_block_lock     = 1'b1;
		i_data           = '0;
		i_max_valid_am   = 3'(MAX_VALID);
		i_max_invalid_am = 3'(MAX_INVALID);
		apply_reset();
		check_reset_outputs();
		// lock on lane 7 with bip3 bad in two of the five checked periods
		for (int k = 1; k <= 9; k++)
			send_period(GOOD_LANE, (k == 6) || (k == 8));
		send_period(WRONG_LANE, 1'b0);	// single bad marker keeps lock
		send_period(GOOD_LANE, 1'b0);
		repeat (3) send_period(WRONG_LANE, 1'b0);	// lock drops here
		flush_and_check();
		// same lock and bip run with holes in i_valid
		gaps_on = 1'b1;
		apply_reset();
		for (int k = 1; k <= 9; k++)
			send_period(GOOD_LANE, (k == 6) || (k == 8));
		flush_and_check();
		$display("blocks checked: %0d, errors: %0d", blocks_checked, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* logic/am_lock_top.sv */
// am lock, one 100G pcs lane
`timescale 1ns/10ps

module am_lock_top
#(
	parameter int AM_PERIOD        = 16384,	// blocks between markers
	parameter int NB_ERROR_COUNTER = 32,
	parameter int NB_VAL_AM        = 3,
	parameter int NB_INV_AM        = 3
)
(
	input  logic                                   i_clock,
	input  logic                                   i_reset,
	input  logic                                   i_enable,
	input  logic                                   i_valid,		// block strobe
	input  logic                                   i_block_lock,	// from block sync
	input  logic [am_lock_pkg::NB_CODED_BLOCK-1:0] i_data,
	input  logic [NB_VAL_AM-1:0]                   i_max_valid_am,	// markers to lock
	input  logic [NB_INV_AM-1:0]                   i_max_invalid_am,	// markers to unlock
	output logic [am_lock_pkg::NB_CODED_BLOCK-1:0] o_data,
	output logic                                   o_valid,
	output logic [am_lock_pkg::NB_LANE_ID-1:0]     o_lane_id,
	output logic                                   o_am_lock,
	output logic                                   o_resync,
	output logic                                   o_start_of_lane,
	output logic [NB_ERROR_COUNTER-1:0]            o_error_count
);

	import am_lock_pkg::*;

	logic [NB_CODED_BLOCK-1:0] in_block;	// stage 1 block
	logic                      in_valid;	// stage 1 strobe
	logic                      restart_timer;
	logic                      period_end;	// stage 1 block sits in a marker slot
	logic                      period_check;
	logic                      bip_error;

	am_compare_if cmp_if ();

	always_ff @(posedge i_clock)
	begin
		if (i_valid)
			in_block <= i_data;	// payload, no reset
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			in_valid <= 1'b0;
			o_valid  <= 1'b0;
		end
		else
		begin
			in_valid <= i_valid;
			o_valid  <= in_valid;	// two cycle latency
		end
	end

	// marker slot swapped for idle while locked
	always_ff @(posedge i_clock)
	begin
		if (in_valid)
			o_data <= (o_am_lock && period_end) ? IDLE_BLOCK : in_block;
	end

	am_comparator u_am_comparator
	(
		.i_block (in_block),
		.cmp     (cmp_if.cmp_side)
	);

	am_lock_fsm
	#(
		.NB_VAL_AM (NB_VAL_AM),
		.NB_INV_AM (NB_INV_AM)
	)
	u_am_lock_fsm
	(
		.i_clock          (i_clock),
		.i_reset          (i_reset),
		.i_enable         (i_enable),
		.i_valid          (in_valid),
		.i_block_lock     (i_block_lock),
		.i_period_end     (period_end),
		.i_max_valid_am   (i_max_valid_am),
		.i_max_invalid_am (i_max_invalid_am),
		.cmp              (cmp_if.fsm_side),
		.o_restart_timer  (restart_timer),
		.o_period_check   (period_check),
		.o_am_lock        (o_am_lock),
		.o_resync         (o_resync),
		.o_start_of_lane  (o_start_of_lane),
		.o_lane_id        (o_lane_id)
	);

	am_period_timer #(.AM_PERIOD (AM_PERIOD)) u_am_period_timer
	(
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_valid      (in_valid),
		.i_restart    (restart_timer),
		.o_period_end (period_end)
	);

	bip_calculator u_bip_calculator
	(
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_valid        (in_valid),
		.i_block        (in_block),
		.i_period_check (period_check),
		.i_am_lock      (o_am_lock),
		.o_bip_error    (bip_error)
	);

	bip_error_counter #(.NB_ERROR_COUNTER (NB_ERROR_COUNTER)) u_bip_error_counter
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_enable      (i_enable),
		.i_bip_error   (bip_error),
		.o_error_count (o_error_count)
	);

endmodule

/* am_lock/bip_error_counter.sv */
// bip error counter
`timescale 1ns/10ps

module bip_error_counter
#(
	parameter int NB_ERROR_COUNTER = 32
)
(
	input  logic                        i_clock,
	input  logic                        i_reset,
	input  logic                        i_enable,
	input  logic                        i_bip_error,	// one pulse per bad period
	output logic [NB_ERROR_COUNTER-1:0] o_error_count
);

	logic at_max;	// saturated

	assign at_max = &o_error_count;

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			o_error_count <= '0;
		else if (i_enable && i_bip_error && !at_max)
			o_error_count <= o_error_count + 1'b1;	// hold at all ones
	end

endmodule

/* am_lock/bip_calculator.sv */
// bip3 accumulate and check
`timescale 1ns/10ps

module bip_calculator
(
	input  logic                                   i_clock,
	input  logic                                   i_reset,
	input  logic                                   i_valid,
	input  logic [am_lock_pkg::NB_CODED_BLOCK-1:0] i_block,
	input  logic                                   i_period_check,	// marker slot in lock states
	input  logic                                   i_am_lock,
	output logic                                   o_bip_error
);

	import am_lock_pkg::*;

	logic [NB_BIP-1:0] bip_acc;	// running parity since last marker
	logic [NB_BIP-1:0] block_bip;	// parity of current block
	logic [NB_BIP-1:0] rx_bip3;	// field carried by the marker
	logic              armed;	// full period gathered in lock

	// bit j collects every block bit with index mod 8 == j, sync bits too
	function automatic logic [NB_BIP-1:0] fold_bip(input logic [NB_CODED_BLOCK-1:0] blk);
		logic [NB_BIP-1:0] acc;
		acc = '0;
		for (int b = 0; b < NB_CODED_BLOCK; b++)
			acc[b % NB_BIP] = acc[b % NB_BIP] ^ blk[b];
		return acc;
	endfunction

	assign block_bip = fold_bip(i_block);
	assign rx_bip3   = i_block[BIP3_LSB +: NB_BIP];

	assign o_bip_error = i_period_check && i_am_lock && armed && (bip_acc != rx_bip3);

	always_ff @(posedge i_clock)
	begin
		if (i_valid)
		begin
			if (i_period_check)
				bip_acc <= block_bip;	// seed with the marker
			else
				bip_acc <= bip_acc ^ block_bip;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset || !i_am_lock)
			armed <= 1'b0;
		else if (i_valid && i_period_check)
			armed <= 1'b1;	// next period starts inside lock
	end

endmodule

/* am_lock/am_lock_fsm.sv */
// alignment marker lock fsm
`timescale 1ns/10ps

module am_lock_fsm
#(
	parameter int NB_VAL_AM = 3,
	parameter int NB_INV_AM = 3
)
(
	input  logic                               i_clock,
	input  logic                               i_reset,
	input  logic                               i_enable,
	input  logic                               i_valid,
	input  logic                               i_block_lock,
	input  logic                               i_period_end,	// marker slot from timer
	input  logic [NB_VAL_AM-1:0]               i_max_valid_am,
	input  logic [NB_INV_AM-1:0]               i_max_invalid_am,
	am_compare_if.fsm_side                     cmp,
	output logic                               o_restart_timer,
	output logic                               o_period_check,	// to bip calc
	output logic                               o_am_lock,
	output logic                               o_resync,
	output logic                               o_start_of_lane,
	output logic [am_lock_pkg::NB_LANE_ID-1:0] o_lane_id
);

	import am_lock_pkg::*;

	lock_state_e          state;
	logic [NB_VAL_AM-1:0] valid_count;	// consecutive good markers
	logic [NB_INV_AM-1:0] invalid_count;	// consecutive bad markers
	logic [NB_VAL_AM:0]   valid_next;	// extra bit, no wrap
	logic [NB_INV_AM:0]   invalid_next;
	logic                 run;		// enabled and block locked

	assign run          = i_enable && i_block_lock;
	assign valid_next   = {1'b0, valid_count} + 1'b1;
	assign invalid_next = {1'b0, invalid_count} + 1'b1;

	assign cmp.mask_enable = (state != ST_SEARCH);	// only chosen lane once found
	assign o_restart_timer = run && i_valid && (state == ST_SEARCH) && cmp.am_match;
	assign o_period_check  = run && i_valid && i_period_end && (state != ST_SEARCH);

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state           <= ST_SEARCH;
			valid_count     <= '0;
			invalid_count   <= '0;
			cmp.match_mask  <= '0;
			o_am_lock       <= 1'b0;
			o_resync        <= 1'b0;
			o_start_of_lane <= 1'b0;
			o_lane_id       <= '0;
		end
		else
		begin
			o_resync        <= 1'b0;	// single cycle pulses
			o_start_of_lane <= 1'b0;
			if (!run)
			begin
				state         <= ST_SEARCH;	// lost block lock or disabled
				o_am_lock     <= 1'b0;
				valid_count   <= '0;
				invalid_count <= '0;
			end
			else if (i_valid)
			begin
				case (state)
					ST_SEARCH:
					begin
						if (cmp.am_match)
						begin
							cmp.match_mask <= cmp.match_vector;	// capture lane
							valid_count    <= NB_VAL_AM'(1);	// first marker counts
							state          <= ST_COUNT;
						end
					end
					ST_COUNT:
					begin
						if (i_period_end && !cmp.am_match)
						begin
							state       <= ST_SEARCH;	// wrong or missing marker
							valid_count <= '0;
						end
						else if (i_period_end && (valid_next >= {1'b0, i_max_valid_am}))
						begin
							state           <= ST_LOCKED;
							o_am_lock       <= 1'b1;
							o_lane_id       <= cmp.lane_id;
							o_start_of_lane <= 1'b1;
							invalid_count   <= '0;
						end
						else if (i_period_end)
							valid_count <= valid_next[NB_VAL_AM-1:0];
					end
					ST_LOCKED, ST_SLIP:
					begin
						if (i_period_end && cmp.am_match)
						begin
							state           <= ST_LOCKED;	// one good marker clears slip
							invalid_count   <= '0;
							o_start_of_lane <= 1'b1;
						end
						else if (i_period_end && (invalid_next >= {1'b0, i_max_invalid_am}))
						begin
							state         <= ST_SEARCH;	// too many bad markers
							o_am_lock     <= 1'b0;
							o_resync      <= 1'b1;
							valid_count   <= '0;
							invalid_count <= '0;
						end
						else if (i_period_end)
						begin
							state         <= ST_SLIP;
							invalid_count <= invalid_next[NB_INV_AM-1:0];
						end
					end
					default:
						state <= ST_SEARCH;
				endcase
			end
		end
	end

endmodule

/* am_lock/am_period_timer.sv */
// marker period timer
`timescale 1ns/10ps

module am_period_timer
#(
	parameter int AM_PERIOD = 16384	// blocks per marker period
)
(
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_valid,
	input  logic i_restart,		// marker found in search
	output logic o_period_end	// this block is a marker slot
);

	localparam int NB_COUNT = $clog2(AM_PERIOD);

	logic [NB_COUNT-1:0] block_count;	// blocks since last marker

	assign o_period_end = i_valid && (block_count == '0);

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			block_count <= '0;
		else if (i_valid)
		begin
			if (i_restart)
				block_count <= NB_COUNT'(1);	// marker itself is slot 0
			else if (block_count == NB_COUNT'(AM_PERIOD - 1))
				block_count <= '0;	// wrap onto next slot
			else
				block_count <= block_count + 1'b1;
		end
	end

endmodule

/* am_lock/am_comparator.sv */
// lane marker comparator
`timescale 1ns/10ps

module am_comparator
(
	input  logic [am_lock_pkg::NB_CODED_BLOCK-1:0] i_block,	// stage 1 block
	am_compare_if.cmp_side                         cmp
);

	import am_lock_pkg::*;

	localparam int NB_HALF = NB_AM / 2;	// 24 bits per marker half

	logic [NB_AM-1:0]       am_value;	// M0..M2 then M4..M6
	logic                   sh_ctrl;
	lane_mask_t             raw_match;	// before lane mask
	logic [NB_LANE_ID-1:0]  lane_enc;

	assign am_value = {i_block[AM_HI_MSB -: NB_HALF], i_block[AM_LO_MSB -: NB_HALF]};
	assign sh_ctrl  = (i_block[NB_CODED_BLOCK-1 -: NB_SH] == CTRL_SH);

	always_comb
	begin
		for (int k = 0; k < N_LANES; k++)
			raw_match[k] = sh_ctrl && (am_value == AM_TABLE[k]);	// bip fields ignored
	end

	// once locked only the captured lane counts
	assign cmp.match_vector = cmp.mask_enable ? (raw_match & cmp.match_mask) : raw_match;
	assign cmp.am_match     = |cmp.match_vector;

	// one-hot to binary, markers are distinct so at most one bit set
	always_comb
	begin
		lane_enc = '0;
		for (int k = 0; k < N_LANES; k++)
		begin
			if (cmp.match_vector[k])
				lane_enc = NB_LANE_ID'(k);
		end
	end

	assign cmp.lane_id = lane_enc;

endmodule

/* common/am_compare_if.sv */
// fsm to comparator link
`timescale 1ns/10ps

interface am_compare_if;

	import am_lock_pkg::*;

	lane_mask_t             match_mask;	// chosen lane, one-hot
	logic                   mask_enable;	// high once a lane is chosen
	logic                   am_match;	// some allowed lane matched
	lane_mask_t             match_vector;	// per-lane match after masking
	logic [NB_LANE_ID-1:0]  lane_id;	// encoded matching lane

	modport fsm_side
	(
		output match_mask,
		output mask_enable,
		input  am_match,
		input  match_vector,
		input  lane_id
	);

	modport cmp_side
	(
		input  match_mask,
		input  mask_enable,
		output am_match,
		output match_vector,
		output lane_id
	);

endinterface

/* common/am_lock_pkg.sv */
// alignment marker lock
// shared widths, fields and lane table
package am_lock_pkg;

	localparam int NB_CODED_BLOCK = 66;	// 64b/66b coded block
	localparam int NB_SH          = 2;	// sync header, top two bits
	localparam int NB_AM          = 48;	// compared marker bytes M0..M2, M4..M6
	localparam int NB_BIP         = 8;	// bip3 / bip7 width
	localparam int N_LANES        = 20;	// pcs lanes in 100G
	localparam int NB_LANE_ID     = 5;	// lane number width

	// field positions inside the coded block
	localparam int AM_HI_MSB = 63;		// M0 msb, M0..M2 span 24 bits
	localparam int AM_LO_MSB = 31;		// M4 msb, M4..M6 span 24 bits
	localparam int BIP3_LSB  = 32;		// bip3 at 39..32

	localparam logic [NB_SH-1:0] CTRL_SH         = 2'b10;	// control block header
	localparam logic [7:0]       BLOCK_TYPE_CTRL = 8'h1E;	// all-control block type

	// idle control block, sync 10 + type 1E + eight idle codes
	localparam logic [NB_CODED_BLOCK-1:0] IDLE_BLOCK =
		{CTRL_SH, BLOCK_TYPE_CTRL, {(NB_CODED_BLOCK-NB_SH-8){1'b0}}};

	// per-lane marker {M0,M1,M2,M4,M5,M6}, M4..M6 are the complements of M0..M2
	localparam logic [NB_AM-1:0] AM_TABLE [N_LANES] = '{
		48'hC16821_3E97DE,	// lane 0
		48'h9D718E_628E71,	// lane 1
		48'h594BE8_A6B417,	// lane 2
		48'h4D957B_B26A84,	// lane 3
		48'hF50709_0AF8F6,	// lane 4
		48'hDD14C2_22EB3D,	// lane 5
		48'h9A4A26_65B5D9,	// lane 6
		48'h7B4566_84BA99,	// lane 7
		48'hA02476_5FDB89,	// lane 8
		48'h68C9FB_973604,	// lane 9
		48'hFD6C99_029366,	// lane 10
		48'hB99155_466EAA,	// lane 11
		48'h5CB9B2_A3464D,	// lane 12
		48'h1AF8BD_E50742,	// lane 13
		48'h83C7CA_7C3835,	// lane 14
		48'hC4314C_3BCEB3,	// lane 15
		48'hADD6B7_522948,	// lane 16
		48'h5F662A_A099D5,	// lane 17
		48'hC0F0E5_3F0F1A,	// lane 18
		48'h262C97_D9D368	// lane 19
	};

	typedef logic [N_LANES-1:0] lane_mask_t;	// one-hot lane select

	typedef enum logic [1:0]
	{
		ST_SEARCH,	// hunting any lane marker
		ST_COUNT,	// lane chosen, counting good markers
		ST_LOCKED,	// locked, no pending bad markers
		ST_SLIP		// locked, bad markers pending
	} lock_state_e;

endpackage
